//--- Makefile
VERILATOR := verilator
VFLAGS    := --timing --assert
TOP       := tb_cpu
FILELIST  := build.f
OBJ_DIR   := obj_dir
LOG       := sim.log
PASS_MSG  := PASS: all tests

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FILELIST) --top-module $(TOP)

sim:
	$(VERILATOR) --binary $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(OBJ_DIR)
	-./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@grep -q "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

//--- build.f
+incdir+.
cpu_pkg.sv
instr_mem.sv
data_mem.sv
register_file.sv
fetch_unit.sv
decode_stage.sv
execute_stage.sv
cpu_top.sv
cpu_properties.sv
tb_cpu.sv

//--- cpu_defines.svh
`ifndef CPU_DEFINES_SVH
`define CPU_DEFINES_SVH

// Datapath widths
`define DATA_W 8
`define INSTR_W 16
`define PC_W 10

// Register index and data memory address
`define REG_ADDR_W 3
`define DMEM_ADDR_W 8

// Opcode field at the top of the instruction word
`define OPCODE_W 5

// Storage depths
`define NUM_REGS 8
`define IMEM_DEPTH 1024
`define DMEM_DEPTH 256

`endif

//--- cpu_pkg.sv
`include "cpu_defines.svh"

// Instruction word layout
//   opcode         15:11
//   destination    10:8
//   op2            6:4
//   op1            2:0
//   LOAD address   7:0
//   STORE address  10:3
//   JMP target     9:0
// STORE writes register op1 to memory
package cpu_pkg;

	typedef logic [`DATA_W-1:0] data_t;
	typedef logic [`INSTR_W-1:0] instr_t;
	typedef logic [`PC_W-1:0] pc_t;
	typedef logic [`REG_ADDR_W-1:0] reg_addr_t;
	typedef logic [`DMEM_ADDR_W-1:0] dmem_addr_t;

	// Unlisted codes decode as NOP
	typedef enum logic [`OPCODE_W-1:0] {
		OP_NOP   = 5'd0,
		OP_ADD   = 5'd1,
		OP_SUB   = 5'd2,
		OP_AND   = 5'd3,
		OP_OR    = 5'd4,
		OP_NOT   = 5'd5,
		OP_SHL   = 5'd6,
		OP_JMP   = 5'd7,
		OP_LOAD  = 5'd8,
		OP_STORE = 5'd9
	} opcode_e;

	// Result select in execute
	typedef enum logic [2:0] {
		SEL_ADD,
		SEL_SUB,
		SEL_AND,
		SEL_OR,
		SEL_NOT,
		SEL_SHL,
		SEL_PASS
	} alu_sel_e;

endpackage

//--- cpu_properties.sv
module cpu_properties
	import cpu_pkg::*;
(
	input logic       clk,
	input logic       reset,
	input logic       reg_wr_en,
	input reg_addr_t  reg_wr_addr,
	input logic       mem_wr_en,
	input dmem_addr_t mem_wr_addr
);

	timeunit 1ns;
	timeprecision 100ps;

	// One retirement per cycle
	assert property (@(posedge clk) disable iff (reset) !(reg_wr_en && mem_wr_en))
		else $error("Register write and store strobe high in the same cycle");

	assert property (@(posedge clk) reset |=> (!reg_wr_en && !mem_wr_en))
		else $error("Write strobe high in the cycle after reset");

	assert property (@(posedge clk) disable iff (reset) reg_wr_en |-> !$isunknown(reg_wr_addr))
		else $error("Register write address unknown while its strobe is high");

	assert property (@(posedge clk) disable iff (reset) mem_wr_en |-> !$isunknown(mem_wr_addr))
		else $error("Store address unknown while its strobe is high");

endmodule

bind cpu_top cpu_properties u_props (
	.clk, .reset, .reg_wr_en, .reg_wr_addr, .mem_wr_en, .mem_wr_addr
);

//--- cpu_top.sv
module cpu_top
	import cpu_pkg::*;
(
	input  logic       clk,
	input  logic       reset,
	input  logic       run,
	input  logic       prog_wr_en,
	input  pc_t        prog_wr_addr,
	input  instr_t     prog_wr_data,
	output logic       reg_wr_en,
	output reg_addr_t  reg_wr_addr,
	output data_t      reg_wr_data,
	output logic       mem_wr_en,
	output dmem_addr_t mem_wr_addr,
	output data_t      mem_wr_data
);

	// Fetch side
	pc_t        imem_rd_addr;
	logic       fetch_valid;
	instr_t     fetch_instr;
	logic       redirect;
	pc_t        redirect_target;

	// Register file ports
	reg_addr_t  rf_rd_addr1;
	reg_addr_t  rf_rd_addr2;
	data_t      rf_rd_data1;
	data_t      rf_rd_data2;

	// Decode to execute
	logic       ex_valid;
	alu_sel_e   ex_sel;
	reg_addr_t  ex_op1_addr;
	reg_addr_t  ex_op2_addr;
	data_t      ex_op1_data;
	data_t      ex_op2_data;
	reg_addr_t  ex_dest;
	logic       ex_reg_write;
	logic       ex_load;
	logic       ex_store;
	logic       ex_jump;
	dmem_addr_t ex_mem_addr;
	pc_t        ex_target;

	// Write-back bus and data memory read
	logic       wb_en;
	reg_addr_t  wb_addr;
	data_t      wb_data;
	dmem_addr_t dmem_rd_addr;
	data_t      dmem_rd_data;

	fetch_unit u_fetch (
		.clk, .reset, .run, .redirect, .redirect_target,
		.imem_rd_addr, .fetch_valid
	);

	instr_mem u_imem (
		.clk, .prog_wr_en, .prog_wr_addr, .prog_wr_data,
		.rd_addr(imem_rd_addr), .rd_data(fetch_instr)
	);

	decode_stage u_decode (
		.clk, .reset, .fetch_instr, .fetch_valid, .redirect,
		.rf_rd_addr1, .rf_rd_addr2, .rf_rd_data1, .rf_rd_data2,
		.wb_en, .wb_addr, .wb_data,
		.ex_valid, .ex_sel, .ex_op1_addr, .ex_op2_addr, .ex_op1_data, .ex_op2_data,
		.ex_dest, .ex_reg_write, .ex_load, .ex_store, .ex_jump, .ex_mem_addr, .ex_target
	);

	register_file u_regs (
		.clk, .reset,
		.rd_addr1(rf_rd_addr1), .rd_addr2(rf_rd_addr2),
		.rd_data1(rf_rd_data1), .rd_data2(rf_rd_data2),
		.wr_en(wb_en), .wr_addr(wb_addr), .wr_data(wb_data)
	);

	execute_stage u_execute (
		.clk, .reset,
		.ex_valid, .ex_sel, .ex_op1_addr, .ex_op2_addr, .ex_op1_data, .ex_op2_data,
		.ex_dest, .ex_reg_write, .ex_load, .ex_store, .ex_jump, .ex_mem_addr, .ex_target,
		.redirect, .redirect_target, .wb_en, .wb_addr, .wb_data,
		.dmem_rd_addr, .dmem_rd_data, .mem_wr_en, .mem_wr_addr, .mem_wr_data
	);

	data_mem u_dmem (
		.clk, .reset,
		.wr_en(mem_wr_en), .wr_addr(mem_wr_addr), .wr_data(mem_wr_data),
		.rd_addr(dmem_rd_addr), .rd_data(dmem_rd_data)
	);

	// Register writes are visible as they retire
	assign reg_wr_en = wb_en;
	assign reg_wr_addr = wb_addr;
	assign reg_wr_data = wb_data;

endmodule

//--- data_mem.sv
`include "cpu_defines.svh"

module data_mem
	import cpu_pkg::*;
(
	input  logic       clk,
	input  logic       reset,
	input  logic       wr_en,
	input  dmem_addr_t wr_addr,
	input  data_t      wr_data,
	input  dmem_addr_t rd_addr,
	output data_t      rd_data
);

	data_t mem [`DMEM_DEPTH];

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			for (int i = 0; i < `DMEM_DEPTH; i++)
				mem[i] <= '0;
		end
		else if (wr_en)
			mem[wr_addr] <= wr_data;
	end

	// Asynchronous so a LOAD finishes in write-back
	assign rd_data = mem[rd_addr];

endmodule

//--- decode_stage.sv
`include "cpu_defines.svh"

module decode_stage
	import cpu_pkg::*;
(
	input  logic       clk,
	input  logic       reset,
	input  instr_t     fetch_instr,
	input  logic       fetch_valid,
	input  logic       redirect,
	output reg_addr_t  rf_rd_addr1,
	output reg_addr_t  rf_rd_addr2,
	input  data_t      rf_rd_data1,
	input  data_t      rf_rd_data2,
	input  logic       wb_en,
	input  reg_addr_t  wb_addr,
	input  data_t      wb_data,
	output logic       ex_valid,
	output alu_sel_e   ex_sel,
	output reg_addr_t  ex_op1_addr,
	output reg_addr_t  ex_op2_addr,
	output data_t      ex_op1_data,
	output data_t      ex_op2_data,
	output reg_addr_t  ex_dest,
	output logic       ex_reg_write,
	output logic       ex_load,
	output logic       ex_store,
	output logic       ex_jump,
	output dmem_addr_t ex_mem_addr,
	output pc_t        ex_target
);

	opcode_e    opcode;
	alu_sel_e   sel;
	logic       reg_write;
	logic       load;
	logic       store;
	logic       jump;
	dmem_addr_t mem_addr;
	data_t      op1_data;
	data_t      op2_data;

	assign opcode = opcode_e'(fetch_instr[`INSTR_W-1 -: `OPCODE_W]);
	assign rf_rd_addr1 = fetch_instr[2:0];
	assign rf_rd_addr2 = fetch_instr[6:4];

	// Opcode decode
	always_comb
	begin
		sel = SEL_PASS;
		load = 1'b0;
		store = 1'b0;
		jump = 1'b0;
		case (opcode)
			OP_ADD:   sel = SEL_ADD;
			OP_SUB:   sel = SEL_SUB;
			OP_AND:   sel = SEL_AND;
			OP_OR:    sel = SEL_OR;
			OP_NOT:   sel = SEL_NOT;
			OP_SHL:   sel = SEL_SHL;
			OP_JMP:   jump = 1'b1;
			OP_LOAD:  load = 1'b1;
			OP_STORE: store = 1'b1;
			default:  ;
		endcase
		// ALU ops and LOAD write a register
		reg_write = (sel != SEL_PASS) || load;
	end

	// STORE carries its address higher up in the word
	assign mem_addr = (opcode == OP_STORE) ? fetch_instr[10:3] : fetch_instr[7:0];

	// Producer two ahead is in write-back right now
	assign op1_data = (wb_en && wb_addr == rf_rd_addr1) ? wb_data : rf_rd_data1;
	assign op2_data = (wb_en && wb_addr == rf_rd_addr2) ? wb_data : rf_rd_data2;

	//**************************************************************************
	// Decode to execute registers
	//**************************************************************************
	always_ff @(posedge clk)
	begin
		if (reset)
			ex_valid <= 1'b0;
		else
			ex_valid <= fetch_valid && !redirect;
	end

	always_ff @(posedge clk)
	begin
		ex_sel <= sel;
		ex_op1_addr <= rf_rd_addr1;
		ex_op2_addr <= rf_rd_addr2;
		ex_op1_data <= op1_data;
		ex_op2_data <= op2_data;
		ex_dest <= fetch_instr[10:8];
		ex_reg_write <= reg_write;
		ex_load <= load;
		ex_store <= store;
		ex_jump <= jump;
		ex_mem_addr <= mem_addr;
		ex_target <= fetch_instr[9:0];
	end

endmodule

//--- execute_stage.sv
module execute_stage
	import cpu_pkg::*;
(
	input  logic       clk,
	input  logic       reset,
	input  logic       ex_valid,
	input  alu_sel_e   ex_sel,
	input  reg_addr_t  ex_op1_addr,
	input  reg_addr_t  ex_op2_addr,
	input  data_t      ex_op1_data,
	input  data_t      ex_op2_data,
	input  reg_addr_t  ex_dest,
	input  logic       ex_reg_write,
	input  logic       ex_load,
	input  logic       ex_store,
	input  logic       ex_jump,
	input  dmem_addr_t ex_mem_addr,
	input  pc_t        ex_target,
	output logic       redirect,
	output pc_t        redirect_target,
	output logic       wb_en,
	output reg_addr_t  wb_addr,
	output data_t      wb_data,
	output dmem_addr_t dmem_rd_addr,
	input  data_t      dmem_rd_data,
	output logic       mem_wr_en,
	output dmem_addr_t mem_wr_addr,
	output data_t      mem_wr_data
);

	data_t      op1;
	data_t      op2;
	data_t      result;
	data_t      wb_result;
	dmem_addr_t wb_mem_addr;
	logic       wb_load;

	//**************************************************************************
	// Operand forwarding and ALU
	//**************************************************************************

	// Producer one ahead sits in write-back
	assign op1 = (wb_en && wb_addr == ex_op1_addr) ? wb_data : ex_op1_data;
	assign op2 = (wb_en && wb_addr == ex_op2_addr) ? wb_data : ex_op2_data;

	always_comb
	begin
		case (ex_sel)
			SEL_ADD: result = op1 + op2;
			SEL_SUB: result = op1 - op2;
			SEL_AND: result = op1 & op2;
			SEL_OR:  result = op1 | op2;
			SEL_NOT: result = ~op1;
			SEL_SHL: result = op1 << 1;
			// STORE data goes through unchanged
			default: result = op1;
		endcase
	end

	// Jump resolves here, squashing the two younger words
	assign redirect = ex_valid && ex_jump;
	assign redirect_target = ex_target;

	//**************************************************************************
	// Execute to write-back registers
	//**************************************************************************
	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			wb_en <= 1'b0;
			mem_wr_en <= 1'b0;
		end
		else
		begin
			wb_en <= ex_valid && ex_reg_write;
			mem_wr_en <= ex_valid && ex_store;
		end
	end

	always_ff @(posedge clk)
	begin
		wb_addr <= ex_dest;
		wb_result <= result;
		wb_mem_addr <= ex_mem_addr;
		wb_load <= ex_load;
	end

	// Write-back select
	assign wb_data = wb_load ? dmem_rd_data : wb_result;

	// One address register serves LOAD and STORE
	assign dmem_rd_addr = wb_mem_addr;
	assign mem_wr_addr = wb_mem_addr;
	assign mem_wr_data = wb_result;

endmodule

//--- fetch_unit.sv
module fetch_unit
	import cpu_pkg::*;
(
	input  logic clk,
	input  logic reset,
	input  logic run,
	input  logic redirect,
	input  pc_t  redirect_target,
	output pc_t  imem_rd_addr,
	output logic fetch_valid
);

	pc_t pc;
	pc_t next_pc;

	// Jump target wins, otherwise step while running
	always_comb
	begin
		if (redirect)
			next_pc = redirect_target;
		else if (run)
			next_pc = pc + pc_t'(1);
		else
			next_pc = pc;
	end

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			pc <= '0;
			fetch_valid <= 1'b0;
		end
		else
		begin
			pc <= next_pc;
			// Word read at this edge is dropped when idle or redirected
			fetch_valid <= run && !redirect;
		end
	end

	assign imem_rd_addr = pc;

endmodule

//--- instr_mem.sv
`include "cpu_defines.svh"

module instr_mem
	import cpu_pkg::*;
(
	input  logic   clk,
	input  logic   prog_wr_en,
	input  pc_t    prog_wr_addr,
	input  instr_t prog_wr_data,
	input  pc_t    rd_addr,
	output instr_t rd_data
);

	instr_t mem [`IMEM_DEPTH];

	// Program load port
	always_ff @(posedge clk)
	begin
		if (prog_wr_en)
			mem[prog_wr_addr] <= prog_wr_data;
	end

	// Registered read so the word lands in decode
	always_ff @(posedge clk)
	begin
		rd_data <= mem[rd_addr];
	end

endmodule

//--- register_file.sv
`include "cpu_defines.svh"

module register_file
	import cpu_pkg::*;
(
	input  logic      clk,
	input  logic      reset,
	input  reg_addr_t rd_addr1,
	input  reg_addr_t rd_addr2,
	output data_t     rd_data1,
	output data_t     rd_data2,
	input  logic      wr_en,
	input  reg_addr_t wr_addr,
	input  data_t     wr_data
);

	data_t regs [`NUM_REGS];

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			for (int i = 0; i < `NUM_REGS; i++)
				regs[i] <= '0;
		end
		else if (wr_en)
			regs[wr_addr] <= wr_data;
	end

	// Both read ports are combinational
	assign rd_data1 = regs[rd_addr1];
	assign rd_data2 = regs[rd_addr2];

endmodule

//--- tb_cpu.sv
module tb_cpu
	import cpu_pkg::*;
();

	timeunit 1ns;
	timeprecision 100ps;

	logic       clk = 1'b0;
	logic       reset;
	logic       run;
	logic       prog_wr_en;
	pc_t        prog_wr_addr;
	instr_t     prog_wr_data;
	logic       reg_wr_en;
	reg_addr_t  reg_wr_addr;
	data_t      reg_wr_data;
	logic       mem_wr_en;
	dmem_addr_t mem_wr_addr;
	data_t      mem_wr_data;

	logic [31:0] lfsr = 32'h548ec702;
	instr_t      prog_q[$];
	logic [31:0] exp_q[$];
	int          tests = 0;
	int          checks = 0;
	int          errors = 0;

	cpu_top DUT (.*);

	always #10 clk = ~clk;

	//**************************************************************************
	// Instruction words and write events
	//**************************************************************************
	function automatic instr_t alu_word(logic [4:0] op, reg_addr_t dest, reg_addr_t src1,
		reg_addr_t src2);
		return {op, dest, 1'b0, src2, 1'b0, src1};
	endfunction

	function automatic instr_t load_word(reg_addr_t dest, dmem_addr_t addr);
		return {OP_LOAD, dest, addr};
	endfunction

	function automatic instr_t store_word(dmem_addr_t addr, reg_addr_t src);
		return {OP_STORE, addr, src};
	endfunction

	function automatic instr_t jump_word(pc_t target);
		return {OP_JMP, 1'b0, target};
	endfunction

	// Tag in the upper half tells register writes from stores
	function automatic logic [31:0] reg_event(reg_addr_t addr, data_t data);
		return {16'h0001, 5'd0, addr, data};
	endfunction

	function automatic logic [31:0] mem_event(dmem_addr_t addr, data_t data);
		return {16'h0002, addr, data};
	endfunction

	function automatic void emit(instr_t word, int gap);
		prog_q.push_back(word);
		repeat (gap) prog_q.push_back('0);
	endfunction

	// Self-jump parks the core
	function automatic void end_program();
		emit(jump_word(pc_t'(prog_q.size())), 0);
	endfunction

	// Galois LFSR stepped once per bit taken
	function automatic logic [31:0] random_bits(int count);
		logic [31:0] value;
		value = '0;
		for (int i = 0; i < count; i++)
		begin
			lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'h80200003) : (lfsr >> 1);
			value = {value[30:0], lfsr[0]};
		end
		return value;
	endfunction

	function automatic void random_program(int count);
		int         kind;
		int         target;
		reg_addr_t  dest;
		reg_addr_t  src1;
		reg_addr_t  src2;
		dmem_addr_t addr;
		for (int i = 0; i < count; i++)
		begin
			kind = int'(random_bits(4)) % 10;
			dest = reg_addr_t'(random_bits(3));
			src1 = reg_addr_t'(random_bits(3));
			src2 = reg_addr_t'(random_bits(3));
			// Few addresses so loads often hit stored bytes
			addr = dmem_addr_t'(random_bits(3));
			case (kind)
				7:
				begin
					target = i + 1 + int'(random_bits(2));
					if (target > count)
						target = count;
					emit(jump_word(pc_t'(target)), 0);
				end
				8: emit(load_word(dest, addr), 0);
				9: emit(store_word(addr, src1), 0);
				default: emit(alu_word(5'(kind), dest, src1, src2), 0);
			endcase
		end
	endfunction

	//**************************************************************************
	// Sequential reference model
	//**************************************************************************
	function automatic void build_expected();
		data_t      regs [8];
		data_t      mem [256];
		instr_t     w;
		logic [4:0] op;
		data_t      a;
		data_t      b;
		data_t      res;
		bit         wr;
		bit         done;
		int         pc;
		int         steps;
		foreach (regs[i])
			regs[i] = '0;
		foreach (mem[i])
			mem[i] = '0;
		exp_q.delete();
		pc = 0;
		steps = 0;
		done = 1'b0;
		while (!done && pc < prog_q.size() && steps < 4096)
		begin
			w = prog_q[pc];
			op = w[15:11];
			a = regs[w[2:0]];
			b = regs[w[6:4]];
			res = '0;
			wr = 1'b1;
			case (op)
				OP_ADD:  res = a + b;
				OP_SUB:  res = a - b;
				OP_AND:  res = a & b;
				OP_OR:   res = a | b;
				OP_NOT:  res = ~a;
				OP_SHL:  res = {a[6:0], 1'b0};
				OP_LOAD: res = mem[w[7:0]];
				default: wr = 1'b0;
			endcase
			if (wr)
			begin
				regs[w[10:8]] = res;
				exp_q.push_back(reg_event(w[10:8], res));
			end
			if (op == OP_STORE)
			begin
				mem[w[10:3]] = a;
				exp_q.push_back(mem_event(w[10:3], a));
			end
			if (op == OP_JMP)
			begin
				done = (int'(w[9:0]) == pc);
				pc = int'(w[9:0]);
			end
			else
				pc++;
			steps++;
		end
	endfunction

	//**************************************************************************
	// Checking
	//**************************************************************************
	task automatic check(string name, logic [31:0] expected, logic [31:0] actual);
		checks++;
		if (expected !== actual)
		begin
			errors++;
			$display("Mismatch in %s: expected %h, actual %h", name, expected, actual);
		end
	endtask

	task automatic expect_quiet(string name, int cycles);
		repeat (cycles)
		begin
			@(negedge clk);
			if (reg_wr_en || mem_wr_en)
			begin
				errors++;
				$display("Unexpected write strobe in %s while the core should be quiet", name);
			end
		end
	endtask

	// Reset, load with run low, run, then match every write in order
	task automatic run_program(string name);
		int start_errors;
		int start_checks;
		int waited;
		start_errors = errors;
		start_checks = checks;
		build_expected();
		@(posedge clk);
		reset <= 1'b1;
		run <= 1'b0;
		repeat (8) @(posedge clk);
		reset <= 1'b0;
		// Two NOP words pad the slots fetched behind the self-jump
		for (int i = 0; i < prog_q.size() + 2; i++)
		begin
			@(posedge clk);
			prog_wr_en <= 1'b1;
			prog_wr_addr <= pc_t'(i);
			prog_wr_data <= (i < prog_q.size()) ? prog_q[i] : '0;
		end
		@(posedge clk);
		prog_wr_en <= 1'b0;
		expect_quiet(name, 12);
		@(posedge clk);
		run <= 1'b1;
		foreach (exp_q[n])
		begin
			waited = 0;
			do
			begin
				@(negedge clk);
				waited++;
			end
			while (!reg_wr_en && !mem_wr_en && waited < 200);
			if (reg_wr_en)
				check(name, exp_q[n], reg_event(reg_wr_addr, reg_wr_data));
			else if (mem_wr_en)
				check(name, exp_q[n], mem_event(mem_wr_addr, mem_wr_data));
			else
			begin
				errors++;
				$display("Timeout in %s: write %0d of %0d never appeared", name, n + 1,
					exp_q.size());
				break;
			end
		end
		expect_quiet(name, 20);
		tests++;
		$display("Test %s: %0d writes checked, %0d errors", name, checks - start_checks,
			errors - start_errors);
		prog_q.delete();
	endtask

	//**************************************************************************
	// Tests
	//**************************************************************************
	initial
	begin
		reset = 1'b1;
		run = 1'b0;
		prog_wr_en = 1'b0;
		prog_wr_addr = '0;
		prog_wr_data = '0;

		// Each ALU op spaced so results come from the register file
		emit(alu_word(OP_NOT, 3'd1, 3'd0, 3'd0), 3);
		emit(alu_word(OP_SHL, 3'd2, 3'd1, 3'd0), 3);
		emit(alu_word(OP_SHL, 3'd3, 3'd2, 3'd0), 3);
		emit(alu_word(OP_NOT, 3'd4, 3'd3, 3'd0), 3);
		emit(alu_word(OP_ADD, 3'd5, 3'd4, 3'd2), 3);
		emit(alu_word(OP_SUB, 3'd6, 3'd4, 3'd1), 3);
		emit(alu_word(OP_AND, 3'd7, 3'd2, 3'd4), 3);
		emit(alu_word(OP_OR, 3'd5, 3'd3, 3'd4), 3);
		emit(alu_word(OP_SUB, 3'd6, 3'd0, 3'd1), 3);
		emit(alu_word(OP_ADD, 3'd7, 3'd1, 3'd1), 3);
		end_program();
		run_program("alu_ops");

		// Dependent chains one, two and three apart
		for (int d = 1; d <= 3; d++)
		begin
			emit(alu_word(OP_NOT, 3'd1, 3'd0, 3'd0), d - 1);
			emit(alu_word(OP_SHL, 3'd2, 3'd1, 3'd0), d - 1);
			emit(alu_word(OP_ADD, 3'd3, 3'd2, 3'd1), d - 1);
			emit(alu_word(OP_SUB, 3'd4, 3'd3, 3'd2), d - 1);
			emit(alu_word(OP_AND, 3'd5, 3'd4, 3'd3), d - 1);
			emit(alu_word(OP_OR, 3'd6, 3'd5, 3'd1), d - 1);
			emit(alu_word(OP_SHL, 3'd6, 3'd6, 3'd0), d - 1);
			emit(alu_word(OP_NOT, 3'd7, 3'd6, 3'd0), d - 1);
			emit(alu_word(OP_ADD, 3'd1, 3'd7, 3'd7), d - 1);
			end_program();
			run_program($sformatf("chain_d%0d", d));
		end

		// Store then load back to back and later
		emit(alu_word(OP_NOT, 3'd1, 3'd0, 3'd0), 0);
		emit(alu_word(OP_SHL, 3'd2, 3'd1, 3'd0), 0);
		emit(store_word(8'h10, 3'd2), 0);
		emit(load_word(3'd3, 8'h10), 0);
		emit(alu_word(OP_ADD, 3'd4, 3'd3, 3'd1), 0);
		emit(store_word(8'h20, 3'd3), 3);
		emit(load_word(3'd5, 8'h20), 0);
		emit(alu_word(OP_SHL, 3'd5, 3'd5, 3'd0), 0);
		emit(load_word(3'd6, 8'h11), 0);
		end_program();
		run_program("store_load");

		// Registers and memory written above must read as zero
		emit(alu_word(OP_ADD, 3'd1, 3'd2, 3'd3), 0);
		emit(alu_word(OP_OR, 3'd4, 3'd5, 3'd6), 0);
		emit(load_word(3'd7, 8'h20), 0);
		emit(load_word(3'd2, 8'h10), 0);
		end_program();
		run_program("fresh_reset");

		// Words 2, 3 and 8 sit in jump shadows, 4 and 5 are skipped
		emit(alu_word(OP_NOT, 3'd1, 3'd0, 3'd0), 0);
		emit(jump_word(10'd6), 0);
		emit(store_word(8'h40, 3'd1), 0);
		emit(alu_word(OP_NOT, 3'd2, 3'd0, 3'd0), 0);
		emit(alu_word(OP_SHL, 3'd3, 3'd1, 3'd0), 0);
		emit(alu_word(OP_NOT, 3'd4, 3'd0, 3'd0), 0);
		emit(alu_word(OP_SHL, 3'd5, 3'd1, 3'd0), 0);
		emit(jump_word(10'd9), 0);
		emit(alu_word(OP_ADD, 3'd6, 3'd5, 3'd1), 0);
		emit(alu_word(OP_ADD, 3'd7, 3'd5, 3'd1), 0);
		end_program();
		run_program("jump_squash");

		random_program(60);
		end_program();
		run_program("random_60");

		$display("Tests run: %0d, writes checked: %0d, errors: %0d", tests, checks, errors);
		if (errors == 0)
			$display("PASS: all tests");
		else
			$display("FAIL: see errors above");
		$finish;
	end

endmodule
